// File: src/tomasulo_pkg.sv
`default_nettype none

package tomasulo_pkg;

    // default machine sizing, the top level may override both
    parameter int ROB_DEPTH = 8;
    parameter int NUM_RS    = 2;

    // rv32i major opcodes handled by the core
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    // wide enough for the default eight rob entries
    typedef logic [2:0]  rob_tag_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU
    } alu_op_t;

    // common data bus broadcast
    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        word_t    data;
    } cdb_word_t;

    // station payload, a source is either a value or the tag it waits on
    typedef struct packed {
        alu_op_t  op;
        logic     src1_valid;
        rob_tag_t src1_tag;
        word_t    src1_data;
        logic     src2_valid;
        rob_tag_t src2_tag;
        word_t    src2_data;
        rob_tag_t dest_tag;
    } res_word_t;

endpackage

`default_nettype wire

// File: src/exec_if.sv
`default_nettype none

// one station's result offer to the bus arbiter
interface exec_if;

    logic                   req;
    logic                   grant;
    tomasulo_pkg::rob_tag_t tag;
    tomasulo_pkg::word_t    result;

    // req, tag and result hold until grant is seen at an edge
    modport station (output req, output tag, output result, input grant);
    modport arbiter (input req, input tag, input result, output grant);

endinterface

`default_nettype wire

// File: src/alu.sv
`default_nettype none

module alu (
    input  wire tomasulo_pkg::alu_op_t op_i,
    input  wire tomasulo_pkg::word_t   a_i,
    input  wire tomasulo_pkg::word_t   b_i,
    output tomasulo_pkg::word_t        result_o
);
    import tomasulo_pkg::*;

    // shifts only look at the low five bits
    logic [4:0] shamt;

    assign shamt = b_i[4:0];

    always_comb begin
        case (op_i)
            ALU_ADD:  result_o = a_i + b_i;
            ALU_SUB:  result_o = a_i - b_i;
            ALU_AND:  result_o = a_i & b_i;
            ALU_OR:   result_o = a_i | b_i;
            ALU_XOR:  result_o = a_i ^ b_i;
            ALU_SLL:  result_o = a_i << shamt;
            ALU_SRL:  result_o = a_i >> shamt;
            ALU_SRA:  result_o = word_t'($signed(a_i) >>> shamt);
            ALU_SLT:  result_o = {31'd0, $signed(a_i) < $signed(b_i)};
            ALU_SLTU: result_o = {31'd0, a_i < b_i};
            default:  result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: src/issue_queue.sv
`default_nettype none

module issue_queue #(
    parameter int QUEUE_DEPTH = 4,
    parameter int NUM_RS      = tomasulo_pkg::NUM_RS
) (
    input  wire                     clk_i,
    input  wire                     arst_n_i,
    input  wire                     instr_valid_i,
    input  wire tomasulo_pkg::word_t     instr_i,
    output logic                    instr_ready_o,
    output tomasulo_pkg::reg_idx_t  rf_src1_o,
    output tomasulo_pkg::reg_idx_t  rf_src2_o,
    input  wire tomasulo_pkg::word_t     rf_val1_i,
    input  wire tomasulo_pkg::word_t     rf_val2_i,
    input  wire                     rf_busy1_i,
    input  wire                     rf_busy2_i,
    input  wire tomasulo_pkg::rob_tag_t  rf_tag1_i,
    input  wire tomasulo_pkg::rob_tag_t  rf_tag2_i,
    output tomasulo_pkg::rob_tag_t  rob_query1_o,
    output tomasulo_pkg::rob_tag_t  rob_query2_o,
    input  wire                     rob_done1_i,
    input  wire                     rob_done2_i,
    input  wire tomasulo_pkg::word_t     rob_val1_i,
    input  wire tomasulo_pkg::word_t     rob_val2_i,
    input  wire tomasulo_pkg::cdb_word_t cdb_i,
    input  wire                     rob_full_i,
    input  wire tomasulo_pkg::rob_tag_t  rob_alloc_tag_i,
    input  wire [NUM_RS-1:0]        rs_empty_i,
    output logic                    rob_alloc_o,
    output tomasulo_pkg::reg_idx_t  alloc_rd_o,
    output logic [NUM_RS-1:0]       rs_load_o,
    output tomasulo_pkg::res_word_t res_word_o
);
    import tomasulo_pkg::*;

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    word_t              fifo_mem [QUEUE_DEPTH];
    logic [PTR_W-1:0]   head_ptr;
    logic [PTR_W-1:0]   tail_ptr;
    logic [CNT_W-1:0]   count;
    logic               push;
    logic               issue;
    word_t              head;
    logic               is_op;
    word_t              imm;
    alu_op_t            op;
    cdb_word_t          src1;
    cdb_word_t          src2;
    logic [NUM_RS-1:0]  rs_sel;

    // operand priority: register file, finished rob entry, bus this cycle, else wait on tag
    function automatic cdb_word_t resolve(input logic busy, input rob_tag_t tag,
                                          input word_t rf_val, input logic rob_done,
                                          input word_t rob_val, input cdb_word_t cdb);
        cdb_word_t src;
        src.tag   = tag;
        src.valid = 1'b1;
        src.data  = rf_val;
        if (busy) begin
            if (rob_done) begin
                src.data = rob_val;
            end else if (cdb.valid && cdb.tag == tag) begin
                src.data = cdb.data;
            end else begin
                src.valid = 1'b0;
                src.data  = '0;
            end
        end
        return src;
    endfunction

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign instr_ready_o = (count != CNT_W'(QUEUE_DEPTH));
    assign push          = instr_valid_i && instr_ready_o;
    // head leaves when a rob slot and a station are both free
    assign issue         = (count != '0) && !rob_full_i && (|rs_empty_i);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else begin
            if (push) begin
                tail_ptr <= next_ptr(tail_ptr);
            end
            if (issue) begin
                head_ptr <= next_ptr(head_ptr);
            end
            if (push && !issue) begin
                count <= count + 1'b1;
            end else if (issue && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            fifo_mem[tail_ptr] <= instr_i;
        end
    end

    // head decode
    assign head  = fifo_mem[head_ptr];
    assign is_op = (head[6:0] == OPC_OP);
    // sign extended i-type immediate
    assign imm   = {{20{head[31]}}, head[31:20]};

    always_comb begin
        case (head[14:12])
            3'b000:  op = (is_op && head[30]) ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            // srai shares funct7 bit 5 with sra
            3'b101:  op = head[30] ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
    end

    assign rf_src1_o    = head[19:15];
    assign rf_src2_o    = head[24:20];
    assign rob_query1_o = rf_tag1_i;
    assign rob_query2_o = rf_tag2_i;

    always_comb begin
        src1 = resolve(rf_busy1_i, rf_tag1_i, rf_val1_i, rob_done1_i, rob_val1_i, cdb_i);
        src2 = resolve(rf_busy2_i, rf_tag2_i, rf_val2_i, rob_done2_i, rob_val2_i, cdb_i);
        // op-imm takes the immediate as its second operand
        if (!is_op) begin
            src2.valid = 1'b1;
            src2.data  = imm;
        end
    end

    assign res_word_o = '{
        op:         op,
        src1_valid: src1.valid,
        src1_tag:   src1.tag,
        src1_data:  src1.data,
        src2_valid: src2.valid,
        src2_tag:   src2.tag,
        src2_data:  src2.data,
        dest_tag:   rob_alloc_tag_i
    };

    // lowest empty station wins
    assign rs_sel      = rs_empty_i & ~(rs_empty_i - 1'b1);
    assign rs_load_o   = issue ? rs_sel : '0;
    assign rob_alloc_o = issue;
    assign alloc_rd_o  = head[11:7];

    // only alu instructions may reach the head
    a_head_opcode: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (count != '0) |-> (head[6:0] == OPC_OP || head[6:0] == OPC_OP_IMM));

endmodule

`default_nettype wire

// File: src/regfile.sv
`default_nettype none

module regfile (
    input  wire                         clk_i,
    input  wire                         arst_n_i,
    input  wire tomasulo_pkg::reg_idx_t src1_i,
    input  wire tomasulo_pkg::reg_idx_t src2_i,
    output tomasulo_pkg::word_t         val1_o,
    output tomasulo_pkg::word_t         val2_o,
    output logic                        busy1_o,
    output logic                        busy2_o,
    output tomasulo_pkg::rob_tag_t      tag1_o,
    output tomasulo_pkg::rob_tag_t      tag2_o,
    input  wire                         alloc_i,
    input  wire tomasulo_pkg::reg_idx_t alloc_rd_i,
    input  wire tomasulo_pkg::rob_tag_t alloc_tag_i,
    input  wire                         commit_i,
    input  wire tomasulo_pkg::reg_idx_t commit_rd_i,
    input  wire tomasulo_pkg::rob_tag_t commit_tag_i,
    input  wire tomasulo_pkg::word_t    commit_data_i
);
    import tomasulo_pkg::*;

    word_t    regs [32];
    logic     busy [32];
    // rob entry that will produce each register
    rob_tag_t tags [32];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
                busy[i] <= 1'b0;
                tags[i] <= '0;
            end
        end else begin
            // x0 stays zero and never busy
            if (commit_i && commit_rd_i != '0) begin
                regs[commit_rd_i] <= commit_data_i;
                // a younger producer keeps the register busy
                if (tags[commit_rd_i] == commit_tag_i) begin
                    busy[commit_rd_i] <= 1'b0;
                end
            end
            // later assignment, so allocation beats the commit clear
            if (alloc_i && alloc_rd_i != '0) begin
                busy[alloc_rd_i] <= 1'b1;
                tags[alloc_rd_i] <= alloc_tag_i;
            end
        end
    end

    assign val1_o  = regs[src1_i];
    assign val2_o  = regs[src2_i];
    assign busy1_o = busy[src1_i];
    assign busy2_o = busy[src2_i];
    assign tag1_o  = tags[src1_i];
    assign tag2_o  = tags[src2_i];

endmodule

`default_nettype wire

// File: src/rob.sv
`default_nettype none

module rob #(
    parameter int ROB_DEPTH = tomasulo_pkg::ROB_DEPTH
) (
    input  wire                          clk_i,
    input  wire                          arst_n_i,
    input  wire                          alloc_i,
    input  wire tomasulo_pkg::reg_idx_t  alloc_rd_i,
    output tomasulo_pkg::rob_tag_t       alloc_tag_o,
    output logic                         full_o,
    input  wire tomasulo_pkg::cdb_word_t cdb_i,
    input  wire tomasulo_pkg::rob_tag_t  query1_i,
    input  wire tomasulo_pkg::rob_tag_t  query2_i,
    output logic                         done1_o,
    output logic                         done2_o,
    output tomasulo_pkg::word_t          val1_o,
    output tomasulo_pkg::word_t          val2_o,
    output logic                         commit_valid_o,
    output tomasulo_pkg::reg_idx_t       commit_rd_o,
    output tomasulo_pkg::rob_tag_t       commit_tag_o,
    output tomasulo_pkg::word_t          commit_data_o
);
    import tomasulo_pkg::*;

    localparam int CNT_W = $clog2(ROB_DEPTH + 1);

    rob_tag_t             head;
    rob_tag_t             tail;
    logic [CNT_W-1:0]     count;
    // entry allocated and entry result written
    logic [ROB_DEPTH-1:0] used;
    logic [ROB_DEPTH-1:0] done;
    reg_idx_t             rd_mem  [ROB_DEPTH];
    word_t                val_mem [ROB_DEPTH];
    logic                 commit;

    function automatic rob_tag_t next_ptr(input rob_tag_t ptr);
        return (ptr == rob_tag_t'(ROB_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // head retires once its result is back
    assign commit = used[head] && done[head];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            used  <= '0;
            done  <= '0;
        end else begin
            if (alloc_i) begin
                used[tail] <= 1'b1;
                done[tail] <= 1'b0;
                tail       <= next_ptr(tail);
            end
            if (cdb_i.valid) begin
                done[cdb_i.tag] <= 1'b1;
            end
            if (commit) begin
                used[head] <= 1'b0;
                head       <= next_ptr(head);
            end
            if (alloc_i && !commit) begin
                count <= count + 1'b1;
            end else if (commit && !alloc_i) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (alloc_i) begin
            rd_mem[tail] <= alloc_rd_i;
        end
        if (cdb_i.valid) begin
            val_mem[cdb_i.tag] <= cdb_i.data;
        end
    end

    assign alloc_tag_o = tail;
    assign full_o      = (count == CNT_W'(ROB_DEPTH));

    // operand lookup for the issue stage
    assign done1_o = done[query1_i];
    assign done2_o = done[query2_i];
    assign val1_o  = val_mem[query1_i];
    assign val2_o  = val_mem[query2_i];

    assign commit_valid_o = commit;
    assign commit_rd_o    = rd_mem[head];
    assign commit_tag_o   = head;
    assign commit_data_o  = val_mem[head];

    // issue stalls while full
    a_no_alloc_full: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        alloc_i |-> !full_o);
    // stations only broadcast tags that are in flight
    a_cdb_in_flight: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        cdb_i.valid |-> used[cdb_i.tag]);

endmodule

`default_nettype wire

// File: src/reservation_station.sv
`default_nettype none

module reservation_station (
    input  wire                          clk_i,
    input  wire                          arst_n_i,
    input  wire                          load_i,
    input  wire tomasulo_pkg::res_word_t res_word_i,
    input  wire tomasulo_pkg::cdb_word_t cdb_i,
    output logic                         empty_o,
    exec_if.station                      exec
);
    import tomasulo_pkg::*;

    logic      busy;
    res_word_t entry;
    word_t     alu_result;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy <= 1'b0;
        end else if (load_i) begin
            busy <= 1'b1;
        end else if (exec.req && exec.grant) begin
            // result went out on the bus
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load_i) begin
            entry <= res_word_i;
        end else if (busy && cdb_i.valid) begin
            // snoop for missing operands
            if (!entry.src1_valid && entry.src1_tag == cdb_i.tag) begin
                entry.src1_valid <= 1'b1;
                entry.src1_data  <= cdb_i.data;
            end
            if (!entry.src2_valid && entry.src2_tag == cdb_i.tag) begin
                entry.src2_valid <= 1'b1;
                entry.src2_data  <= cdb_i.data;
            end
        end
    end

    alu u_alu (
        .op_i     (entry.op),
        .a_i      (entry.src1_data),
        .b_i      (entry.src2_data),
        .result_o (alu_result)
    );

    assign empty_o     = !busy;
    // wake up once both operands are in
    assign exec.req    = busy && entry.src1_valid && entry.src2_valid;
    assign exec.tag    = entry.dest_tag;
    assign exec.result = alu_result;

    // an ungranted offer holds steady into the next cycle
    a_req_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        exec.req && !exec.grant |=> exec.req && $stable(exec.tag) && $stable(exec.result));

endmodule

`default_nettype wire

// File: src/cdb_arbiter.sv
`default_nettype none

module cdb_arbiter #(
    parameter int NUM_RS = tomasulo_pkg::NUM_RS
) (
    exec_if.arbiter                 exec [NUM_RS],
    output tomasulo_pkg::cdb_word_t cdb_o
);
    import tomasulo_pkg::*;

    logic [NUM_RS-1:0] req;
    logic [NUM_RS-1:0] grant;
    rob_tag_t          tags    [NUM_RS];
    word_t             results [NUM_RS];

    // interface arrays need constant indices
    for (genvar i = 0; i < NUM_RS; i++) begin : g_port
        assign req[i]        = exec[i].req;
        assign tags[i]       = exec[i].tag;
        assign results[i]    = exec[i].result;
        assign exec[i].grant = grant[i];
    end

    always_comb begin
        grant = '0;
        cdb_o = '0;
        // walk down so the lowest requester is the last one kept
        for (int i = NUM_RS - 1; i >= 0; i--) begin
            if (req[i]) begin
                grant    = '0;
                grant[i] = 1'b1;
                cdb_o    = '{valid: 1'b1, tag: tags[i], data: results[i]};
            end
        end
    end

    // two requesting stations never carry the same rob tag
    always_comb begin
        for (int i = 0; i < NUM_RS; i++) begin
            for (int j = i + 1; j < NUM_RS; j++) begin
                a_tag_unique: assert final (!(req[i] && req[j]) || tags[i] != tags[j]);
            end
        end
    end

endmodule

`default_nettype wire

// File: src/tomasulo_core.sv
`default_nettype none

module tomasulo_core #(
    parameter int ROB_DEPTH   = tomasulo_pkg::ROB_DEPTH,
    parameter int NUM_RS      = tomasulo_pkg::NUM_RS,
    parameter int QUEUE_DEPTH = 4
) (
    input  wire         clk_i,
    input  wire         arst_n_i,
    input  wire         instr_valid_i,
    input  wire  [31:0] instr_i,
    output logic        instr_ready_o,
    output logic        commit_valid_o,
    output logic [4:0]  commit_rd_o,
    output logic [31:0] commit_data_o
);
    import tomasulo_pkg::*;

    cdb_word_t         cdb;
    reg_idx_t          rf_src1;
    reg_idx_t          rf_src2;
    word_t             rf_val1;
    word_t             rf_val2;
    logic              rf_busy1;
    logic              rf_busy2;
    rob_tag_t          rf_tag1;
    rob_tag_t          rf_tag2;
    rob_tag_t          rob_query1;
    rob_tag_t          rob_query2;
    logic              rob_done1;
    logic              rob_done2;
    word_t             rob_val1;
    word_t             rob_val2;
    logic              rob_full;
    logic              rob_alloc;
    rob_tag_t          alloc_tag;
    reg_idx_t          alloc_rd;
    logic [NUM_RS-1:0] rs_empty;
    logic [NUM_RS-1:0] rs_load;
    res_word_t         res_word;
    rob_tag_t          commit_tag;

    // one result channel per station
    exec_if exec_bus [NUM_RS] ();

    issue_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .NUM_RS      (NUM_RS)
    ) u_issue_queue (
        .clk_i, .arst_n_i, .instr_valid_i, .instr_i, .instr_ready_o,
        .rf_src1_o       (rf_src1),
        .rf_src2_o       (rf_src2),
        .rf_val1_i       (rf_val1),
        .rf_val2_i       (rf_val2),
        .rf_busy1_i      (rf_busy1),
        .rf_busy2_i      (rf_busy2),
        .rf_tag1_i       (rf_tag1),
        .rf_tag2_i       (rf_tag2),
        .rob_query1_o    (rob_query1),
        .rob_query2_o    (rob_query2),
        .rob_done1_i     (rob_done1),
        .rob_done2_i     (rob_done2),
        .rob_val1_i      (rob_val1),
        .rob_val2_i      (rob_val2),
        .cdb_i           (cdb),
        .rob_full_i      (rob_full),
        .rob_alloc_tag_i (alloc_tag),
        .rs_empty_i      (rs_empty),
        .rob_alloc_o     (rob_alloc),
        .alloc_rd_o      (alloc_rd),
        .rs_load_o       (rs_load),
        .res_word_o      (res_word)
    );

    regfile u_regfile (
        .clk_i, .arst_n_i,
        .src1_i        (rf_src1),
        .src2_i        (rf_src2),
        .val1_o        (rf_val1),
        .val2_o        (rf_val2),
        .busy1_o       (rf_busy1),
        .busy2_o       (rf_busy2),
        .tag1_o        (rf_tag1),
        .tag2_o        (rf_tag2),
        .alloc_i       (rob_alloc),
        .alloc_rd_i    (alloc_rd),
        .alloc_tag_i   (alloc_tag),
        .commit_i      (commit_valid_o),
        .commit_rd_i   (commit_rd_o),
        .commit_tag_i  (commit_tag),
        .commit_data_i (commit_data_o)
    );

    rob #(
        .ROB_DEPTH (ROB_DEPTH)
    ) u_rob (
        .clk_i, .arst_n_i,
        .alloc_i        (rob_alloc),
        .alloc_rd_i     (alloc_rd),
        .alloc_tag_o    (alloc_tag),
        .full_o         (rob_full),
        .cdb_i          (cdb),
        .query1_i       (rob_query1),
        .query2_i       (rob_query2),
        .done1_o        (rob_done1),
        .done2_o        (rob_done2),
        .val1_o         (rob_val1),
        .val2_o         (rob_val2),
        .commit_valid_o (commit_valid_o),
        .commit_rd_o    (commit_rd_o),
        .commit_tag_o   (commit_tag),
        .commit_data_o  (commit_data_o)
    );

    for (genvar i = 0; i < NUM_RS; i++) begin : g_rs
        reservation_station u_rs (
            .clk_i, .arst_n_i,
            .load_i     (rs_load[i]),
            .res_word_i (res_word),
            .cdb_i      (cdb),
            .empty_o    (rs_empty[i]),
            .exec       (exec_bus[i])
        );
    end

    cdb_arbiter #(
        .NUM_RS (NUM_RS)
    ) u_cdb_arbiter (
        .exec  (exec_bus),
        .cdb_o (cdb)
    );

endmodule

`default_nettype wire

// File: testbench/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 2
) (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD / 2) clk_o = ~clk_o;
        end
    end

    // release on a falling edge, away from the flops
    initial begin
        arst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        arst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

// File: testbench/tb_tomasulo.sv
`default_nettype none

module tb_tomasulo;
    import tomasulo_pkg::*;

    // rv32i opcodes and funct3 codes
    localparam logic [6:0] RV_OP     = 7'b0110011;
    localparam logic [6:0] RV_OP_IMM = 7'b0010011;
    localparam logic [2:0] F_ADD     = 3'd0;
    localparam logic [2:0] F_SLL     = 3'd1;
    localparam logic [2:0] F_XOR     = 3'd4;
    localparam logic [2:0] F_SR      = 3'd5;
    localparam logic [2:0] F_OR      = 3'd6;
    // r-type order add sub sll slt sltu xor srl sra or and
    localparam logic [29:0] R_F3  = {3'd7, 3'd6, 3'd5, 3'd5, 3'd4, 3'd3, 3'd2, 3'd1, 3'd0, 3'd0};
    localparam logic [9:0]  R_ALT = 10'b00_1000_0010;
    // i-type order addi slti sltiu xori ori andi slli srli srai
    localparam logic [26:0] I_F3  = {3'd5, 3'd5, 3'd1, 3'd7, 3'd6, 3'd4, 3'd3, 3'd2, 3'd0};

    logic     clk;
    logic     arst_n;
    logic     instr_valid;
    word_t    instr;
    logic     instr_ready;
    logic     commit_valid;
    reg_idx_t commit_rd;
    word_t    commit_data;

    // golden architectural state, in program order
    word_t    gold_regs [32];
    reg_idx_t exp_rd [$];
    word_t    exp_data [$];
    int       sent_count   = 0;
    int       commit_count = 0;
    int       stall_cycles = 0;
    int       cycle_count  = 0;
    int       seed;

    tb_clock_gen #(
        .PERIOD       (100),
        .RESET_CYCLES (2)
    ) u_clock_gen (
        .clk_o    (clk),
        .arst_n_o (arst_n)
    );

    tomasulo_core #(
        .ROB_DEPTH   (tomasulo_pkg::ROB_DEPTH),
        .NUM_RS      (tomasulo_pkg::NUM_RS),
        .QUEUE_DEPTH (4)
    ) UUT (
        .clk_i          (clk),
        .arst_n_i       (arst_n),
        .instr_valid_i  (instr_valid),
        .instr_i        (instr),
        .instr_ready_o  (instr_ready),
        .commit_valid_o (commit_valid),
        .commit_rd_o    (commit_rd),
        .commit_data_o  (commit_data)
    );

    // isa semantics, sra and slt built from plain shifts and compares
    function automatic word_t ref_alu(input logic [2:0] funct3, input logic alt,
                                      input word_t a, input word_t b);
        logic [4:0] sh;
        word_t      fill;
        sh   = b[4:0];
        fill = a[31] ? ~(32'hffff_ffff >> sh) : 32'h0;
        case (funct3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << sh;
            3'b010:  return (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
            3'b011:  return {31'd0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return alt ? ((a >> sh) | fill) : (a >> sh);
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic check_commit_rd(input reg_idx_t expected, input reg_idx_t actual);
        if (actual !== expected) begin
            $display("[FAIL] commit_rd_o expected %h actual %h", expected, actual);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    task automatic check_commit_data(input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("[FAIL] commit_data_o expected %h actual %h", expected, actual);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    // called at posedge + 10, returns at posedge + 10 after acceptance
    task automatic send_instr(input word_t ins, input reg_idx_t rd, input word_t result);
        logic accepted;
        accepted = 1'b0;
        exp_rd.push_back(rd);
        exp_data.push_back(result);
        if (rd != 5'd0) begin
            gold_regs[rd] = result;
        end
        instr_valid = 1'b1;
        instr       = ins;
        while (!accepted) begin
            // ready only moves at an edge
            accepted = instr_ready;
            if (!accepted) begin
                stall_cycles++;
            end
            @(posedge clk);
            #10;
        end
        instr_valid = 1'b0;
        sent_count++;
    endtask

    task automatic issue_r(input logic [2:0] funct3, input logic alt, input reg_idx_t rd,
                           input reg_idx_t rs1, input reg_idx_t rs2);
        word_t ins;
        ins = {1'b0, alt, 5'd0, rs2, rs1, funct3, rd, RV_OP};
        send_instr(ins, rd, ref_alu(funct3, alt, gold_regs[rs1], gold_regs[rs2]));
    endtask

    task automatic issue_i(input logic [2:0] funct3, input logic [11:0] imm,
                           input reg_idx_t rd, input reg_idx_t rs1);
        word_t ins;
        logic  alt;
        ins = {imm, rs1, funct3, rd, RV_OP_IMM};
        // only srai uses imm bit 10 as a mode bit
        alt = (funct3 == F_SR) && imm[10];
        send_instr(ins, rd, ref_alu(funct3, alt, gold_regs[rs1], {{20{imm[11]}}, imm}));
    endtask

    // any 32 bit value from addi, slli and ori
    task automatic load_const(input reg_idx_t rd, input word_t value);
        issue_i(F_ADD, {1'b0, value[31:21]}, rd, 5'd0);
        issue_i(F_SLL, 12'd11, rd, rd);
        issue_i(F_OR, {1'b0, value[20:10]}, rd, rd);
        issue_i(F_SLL, 12'd10, rd, rd);
        issue_i(F_OR, {2'b0, value[9:0]}, rd, rd);
    endtask

    task automatic test_reset_state();
        check_flag("commit_valid_o", 1'b0, commit_valid);
        check_flag("instr_ready_o", 1'b1, instr_ready);
        issue_i(F_ADD, 12'd5, 5'd1, 5'd0);
        issue_i(F_ADD, 12'h7ff, 5'd2, 5'd0);
        issue_i(F_ADD, 12'h800, 5'd3, 5'd0);
        issue_i(F_ADD, 12'hfff, 5'd4, 5'd0);
    endtask

    task automatic test_dep_chain();
        issue_i(F_ADD, 12'd3, 5'd5, 5'd0);
        issue_r(F_ADD, 1'b0, 5'd6, 5'd5, 5'd5);
        // each add reads the two previous results
        for (int i = 7; i < 12; i++) begin
            issue_r(F_ADD, 1'b0, reg_idx_t'(i), reg_idx_t'(i - 1), reg_idx_t'(i - 2));
        end
    endtask

    // operands in x12 and x13, every r and i form
    task automatic test_ops_round(input word_t a, input word_t b,
                                  input logic [11:0] imm_fixed, input logic random_imm);
        logic [11:0] imm;
        logic [2:0]  f3;
        load_const(5'd12, a);
        load_const(5'd13, b);
        for (int k = 0; k < 10; k++) begin
            issue_r(R_F3[3*k +: 3], R_ALT[k], reg_idx_t'(14 + k), 5'd12, 5'd13);
        end
        for (int k = 0; k < 9; k++) begin
            f3  = I_F3[3*k +: 3];
            imm = random_imm ? 12'($random(seed)) : imm_fixed;
            // shift immediates carry only shamt plus the srai bit
            if (f3 == F_SLL || f3 == F_SR) begin
                imm = {(k == 8) ? 7'h20 : 7'h00, imm[4:0]};
            end
            issue_i(f3, imm, reg_idx_t'(24 + k % 8), 5'd12);
        end
    endtask

    task automatic test_all_ops();
        test_ops_round(word_t'($random(seed)), word_t'($random(seed)), 12'd0, 1'b1);
        test_ops_round(word_t'($random(seed)), word_t'($random(seed)), 12'd0, 1'b1);
        // sign bit corners for slt, sltu and sra
        test_ops_round(32'h8000_0000, 32'h7fff_ffff, 12'h800, 1'b0);
        test_ops_round(32'h7fff_ffff, 32'hffff_ffff, 12'hfff, 1'b0);
        test_ops_round(32'hffff_ffff, 32'h8000_0000, 12'h7ff, 1'b0);
    endtask

    task automatic test_burst();
        int stalls_before;
        stalls_before = stall_cycles;
        issue_i(F_ADD, 12'd1, 5'd16, 5'd0);
        // x16 chain mixed with independent addi
        for (int i = 0; i < 20; i++) begin
            if (i % 3 == 2) begin
                issue_i(F_ADD, 12'($random(seed)), reg_idx_t'(17 + i % 4), 5'd0);
            end else begin
                issue_r(F_ADD, 1'b0, 5'd16, 5'd16, reg_idx_t'(17 + (i + 1) % 4));
            end
        end
        $display("burst saw instr_ready_o low for %0d cycles", stall_cycles - stalls_before);
    endtask

    task automatic test_x0();
        issue_i(F_ADD, 12'd77, 5'd0, 5'd0);
        // computed data still shows on commit
        issue_r(F_ADD, 1'b0, 5'd0, 5'd12, 5'd13);
        issue_r(F_ADD, 1'b0, 5'd26, 5'd0, 5'd0);
        issue_r(F_ADD, 1'b0, 5'd27, 5'd0, 5'd12);
    endtask

    task automatic test_same_reg();
        issue_i(F_ADD, 12'd11, 5'd28, 5'd0);
        issue_i(F_ADD, 12'd22, 5'd28, 5'd0);
        // reads right behind the writes span the cycle where only the older one has retired
        for (int i = 0; i < 4; i++) begin
            issue_r(F_ADD, 1'b0, 5'd29, 5'd28, 5'd0);
        end
        // several x28 writers in flight, readers follow the youngest
        issue_r(F_XOR, 1'b0, 5'd28, 5'd12, 5'd13);
        issue_i(F_ADD, 12'd5, 5'd28, 5'd28);
        issue_r(F_OR, 1'b0, 5'd30, 5'd28, 5'd28);
        // idle so the read comes from the register file
        repeat (10) @(posedge clk);
        #10;
        issue_r(F_ADD, 1'b0, 5'd31, 5'd28, 5'd0);
    endtask

    // commit monitor, mid cycle
    always @(negedge clk) begin
        if (arst_n && commit_valid) begin
            if (exp_rd.size() == 0) begin
                $display("commit of x%0d arrived with no instruction outstanding", commit_rd);
                $display("Errors found");
                $fatal(1);
            end else begin
                check_commit_rd(exp_rd.pop_front(), commit_rd);
                check_commit_data(exp_data.pop_front(), commit_data);
                commit_count++;
            end
        end
    end

    // watchdog, budget grows with each instruction sent
    initial begin
        forever begin
            @(posedge clk);
            cycle_count++;
            if (cycle_count > 40 * sent_count + 100) begin
                $display("timeout after %0d cycles, %0d sent and %0d committed",
                         cycle_count, sent_count, commit_count);
                $display("Errors found");
                $fatal(1);
            end
        end
    end

    initial begin
        seed        = 32'h2e415730;
        instr_valid = 1'b0;
        instr       = '0;
        for (int i = 0; i < 32; i++) begin
            gold_regs[i] = '0;
        end
        @(posedge arst_n);
        @(posedge clk);
        #10;
        test_reset_state();
        test_dep_chain();
        test_all_ops();
        test_burst();
        test_x0();
        test_same_reg();
        // drain the rob
        while (exp_rd.size() != 0) begin
            @(posedge clk);
        end
        // a stray extra commit in these cycles still reaches the monitor
        repeat (5) @(posedge clk);
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
src/tomasulo_pkg.sv
src/exec_if.sv
src/alu.sv
src/issue_queue.sv
src/regfile.sv
src/rob.sv
src/reservation_station.sv
src/cdb_arbiter.sv
src/tomasulo_core.sv
testbench/tb_clock_gen.sv
testbench/tb_tomasulo.sv
